//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f list.f --top-module sdramCmdGenTb -Mdir obj_dir -o simv
	./obj_dir/simv | tee sim.log
	grep -q "test passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- list.f
src/sdramPkg.sv
src/reqPkg.sv
src/initSequencer.sv
src/robFetch.sv
src/cmdQueue.sv
src/refreshTimer.sv
src/bankSequencer.sv
src/pinEncoder.sv
src/sdramCmdGen.sv
tests/sdramCmdGenTb.sv

//--- src/bankSequencer.sv
`timescale 1ns/100ps
// Bank sequencer that turns a queued request or a refresh into a timed command sequence
module bankSequencer import sdramPkg::*, reqPkg::*; (
    input  logic       sclk,
    input  logic       sresetn,
    input  sdramCmdT   initCmd,
    input  logic       initDone,
    input  logic       empty,
    input  queueEntryT head,
    output logic       pop,
    input  logic       refreshReq,
    output logic       refreshAck,
    output logic       qwdRd,
    output qwdAddrT    qwdAddr,
    output sdramCmdT   cmd,
    output bankT       cmdBank,
    output sdramAddrT  cmdAddr
);

    typedef enum logic [2:0] {
        waitInit,
        idle,
        activate,
        column,
        drain,
        precharge,
        prechargeWait,
        refreshWait
    } seqStateT;

    seqStateT   state;
    waitT       waitCnt;   // Shared by every timed wait
    queueEntryT cur;       // Request in service
    logic       colIssue;

    assign colIssue = (state == column) && (waitCnt == '0);

    always_ff @(posedge sclk or negedge sresetn) begin
        if (!sresetn) begin
            state   <= waitInit;
            waitCnt <= '0;
        end else begin
            case (state)
                waitInit: begin
                    if (initDone)
                        state <= idle;
                end
                idle: begin
                    // Refresh goes ahead of the queue head
                    if (refreshReq) begin
                        waitCnt <= waitT'(T_CBR - 2);
                        state   <= refreshWait;
                    end else if (!empty) begin
                        state <= activate;
                    end
                end
                activate: begin
                    waitCnt <= waitT'(T_RCD - 1);  // Column command T_RCD after ACT
                    state   <= column;
                end
                column: begin
                    if (!colIssue) begin
                        waitCnt <= waitCnt - 1'b1;
                    end else begin
                        waitCnt <= cur.isWrite ? waitT'(T_WR + T_CP - 2)
                                               : waitT'(T_CAS + T_BL + T_CP - 2);
                        state   <= drain;
                    end
                end
                drain: begin
                    if (waitCnt == '0)
                        state <= precharge;
                    else
                        waitCnt <= waitCnt - 1'b1;
                end
                precharge: begin
                    waitCnt <= waitT'(T_PR - 2);
                    state   <= prechargeWait;
                end
                default: begin
                    // prechargeWait and refreshWait
                    if (waitCnt == '0)
                        state <= idle;
                    else
                        waitCnt <= waitCnt - 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge sclk) begin
        if (state == activate)
            cur <= head;  // Captured as it leaves the queue
    end

    assign pop        = (state == activate);
    assign refreshAck = (state == idle) && refreshReq;
    assign qwdRd      = colIssue && cur.isWrite;  // Store answers in the WR pin cycle
    assign qwdAddr    = cur.col[6:2];

    always_comb begin
        cmd     = cmdNop;
        cmdBank = cur.bank;
        cmdAddr = sdramAddrT'(cur.col);
        case (state)
            waitInit: begin
                cmd     = initCmd;
                cmdBank = '0;
                cmdAddr = MODE_WORD;  // Only the mode load reads it
            end
            idle: begin
                if (refreshReq)
                    cmd = cmdRefresh;
            end
            activate: begin
                cmd     = cmdAct;
                cmdBank = head.bank;
                cmdAddr = head.row;
            end
            column: begin
                if (colIssue)
                    cmd = cur.isWrite ? cmdWrite : cmdRead;
            end
            precharge: cmd = cmdPreBank;
            default:   cmd = cmdNop;
        endcase
    end

    // Every activate is followed by its column command after exactly T_RCD
    assert property (@(posedge sclk) disable iff (!sresetn)
        cmd == cmdAct |-> ##T_RCD (cmd == cmdRead || cmd == cmdWrite));

endmodule

//--- src/cmdQueue.sv
`timescale 1ns/100ps
// Command queue, a small first-word-fall-through FIFO of access requests
module cmdQueue import reqPkg::*; #(
    parameter int DEPTH = 4  // Power of two
) (
    input  logic       sclk,
    input  logic       sresetn,
    input  logic       push,
    input  queueEntryT pushEntry,
    input  logic       pop,
    output queueEntryT head,
    output logic       empty,
    output logic       full
);

    queueEntryT                 mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]   wrPtr;
    logic [$clog2(DEPTH)-1:0]   rdPtr;
    logic [$clog2(DEPTH):0]     count;

    always_ff @(posedge sclk) begin
        if (push)
            mem[wrPtr] <= pushEntry;
    end

    always_ff @(posedge sclk or negedge sresetn) begin
        if (!sresetn) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push)
                wrPtr <= wrPtr + 1'b1;  // Wraps on its own
            if (pop)
                rdPtr <= rdPtr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head  = mem[rdPtr];  // Head is visible without a read strobe
    assign empty = (count == '0);
    assign full  = (count == ($clog2(DEPTH) + 1)'(DEPTH));

    // Writer and reader live in other blocks
    assert property (@(posedge sclk) disable iff (!sresetn)
        push |-> !full);

    assert property (@(posedge sclk) disable iff (!sresetn)
        pop |-> !empty);

endmodule

//--- src/initSequencer.sv
`timescale 1ns/100ps
// Start-up sequencer that precharges all banks, loads the mode register and reports ready
module initSequencer import sdramPkg::*; (
    input  logic     sclk,
    input  logic     sresetn,
    output sdramCmdT initCmd,
    output logic     initDone
);

    typedef enum logic [2:0] {preAll, preWait, load, loadWait, done} initStateT;

    initStateT state;
    waitT      waitCnt;

    always_ff @(posedge sclk or negedge sresetn) begin
        if (!sresetn) begin
            state   <= preAll;
            waitCnt <= '0;
        end else begin
            case (state)
                preAll: begin
                    waitCnt <= waitT'(T_CBR - 2);  // Mode load lands T_CBR after PreAll
                    state   <= preWait;
                end
                preWait: begin
                    if (waitCnt == '0)
                        state <= load;
                    else
                        waitCnt <= waitCnt - 1'b1;
                end
                load: begin
                    waitCnt <= waitT'(T_LD - 2);
                    state   <= loadWait;
                end
                loadWait: begin
                    if (waitCnt == '0)
                        state <= done;
                    else
                        waitCnt <= waitCnt - 1'b1;
                end
                default: state <= done;  // Parked for good
            endcase
        end
    end

    always_comb begin
        case (state)
            preAll:  initCmd = cmdPreAll;
            load:    initCmd = cmdLoadMode;
            default: initCmd = cmdNop;
        endcase
    end

    assign initDone = (state == done);

    // Ready is sticky and the sequencer stays silent afterwards
    assert property (@(posedge sclk) disable iff (!sresetn)
        initDone |=> initDone && initCmd == cmdNop);

endmodule

//--- src/pinEncoder.sv
`timescale 1ns/100ps
// Pin encoder that registers each command onto the SDRAM control, address and data pins
module pinEncoder import sdramPkg::*, reqPkg::*; (
    input  logic      sclk,
    input  logic      sresetn,
    input  sdramCmdT  cmd,
    input  bankT      cmdBank,
    input  sdramAddrT cmdAddr,
    input  wrDataT    qwdData,
    output sdramPinsT pins,
    output dataT      dq
);

    sdramPinsT pinsNext;
    sdramPinsT pinsQ;

    // Standard RAS/CAS/WE encoding
    always_comb begin
        pinsNext = PINS_NOP;
        case (cmd)
            cmdPreAll, cmdPreBank: begin
                pinsNext.rasn     = 1'b0;
                pinsNext.wen      = 1'b0;
                pinsNext.bank     = cmdBank;
                pinsNext.addr[10] = 1'b1;
            end
            cmdAct: begin
                pinsNext.rasn = 1'b0;
                pinsNext.bank = cmdBank;
                pinsNext.addr = cmdAddr;  // Row
            end
            cmdRead: begin
                pinsNext.casn = 1'b0;
                pinsNext.bank = cmdBank;
                pinsNext.addr = cmdAddr;  // Column
            end
            cmdWrite: begin
                pinsNext.casn = 1'b0;
                pinsNext.wen  = 1'b0;
                pinsNext.bank = cmdBank;
                pinsNext.addr = cmdAddr;
                pinsNext.dqOe = 1'b1;
            end
            cmdRefresh: begin
                pinsNext.rasn = 1'b0;
                pinsNext.casn = 1'b0;
            end
            cmdLoadMode: begin
                pinsNext.rasn = 1'b0;
                pinsNext.casn = 1'b0;
                pinsNext.wen  = 1'b0;
                pinsNext.addr = cmdAddr;  // Bank stays 0
            end
            default: pinsNext = PINS_NOP;
        endcase
    end

    always_ff @(posedge sclk or negedge sresetn) begin
        if (!sresetn)
            pinsQ <= PINS_NOP;
        else
            pinsQ <= pinsNext;
    end

    // Store word arrives during the WR cycle and goes straight to the bus
    always_comb begin
        pins = pinsQ;
        if (pinsQ.dqOe)
            pins.dqm = qwdData.mask;
    end

    assign dq = pinsQ.dqOe ? qwdData.data : '0;

endmodule

//--- src/refreshTimer.sv
`timescale 1ns/100ps
// Refresh timer that counts the refresh interval and holds a request until served
module refreshTimer import sdramPkg::*; (
    input  logic sclk,
    input  logic sresetn,
    output logic refreshReq,
    input  logic refreshAck
);

    refCntT refCnt;

    always_ff @(posedge sclk or negedge sresetn) begin
        if (!sresetn) begin
            refCnt     <= refCntT'(T_RFC - 1);
            refreshReq <= 1'b0;
        end else begin
            if (refCnt == '0)
                refCnt <= refCntT'(T_RFC - 1);  // Free running, one period per T_RFC
            else
                refCnt <= refCnt - 1'b1;

            if (refCnt == '0)
                refreshReq <= 1'b1;
            else if (refreshAck)
                refreshReq <= 1'b0;
        end
    end

    // Sequencer acknowledges only a pending request
    assert property (@(posedge sclk) disable iff (!sresetn)
        refreshAck |-> refreshReq);

endmodule

//--- src/reqPkg.sv
// Request package with ROB entry, command queue entry and write-data word
package reqPkg;

    import sdramPkg::*;

    typedef logic [10:0] rowT;
    typedef logic [7:0]  colT;
    typedef logic [4:0]  qwdAddrT;
    typedef logic [1:0]  losT;

    // Access type codes of a ROB entry
    localparam losT LOS_WRITE = 2'b01;
    localparam losT LOS_READ  = 2'b10;

    typedef struct packed {
        logic [10:0] dAddr;  // Device address, ignored here
        logic [1:0]  size;   // Ignored here
        losT         los;
        bankT        bank;
        rowT         row;
        colT         col;
    } robEntryT;

    typedef struct packed {
        logic isWrite;
        bankT bank;
        rowT  row;
        colT  col;
    } queueEntryT;

    typedef struct packed {
        dataT data;
        maskT mask;
    } wrDataT;

endpackage

//--- src/robFetch.sv
`timescale 1ns/100ps
// ROB fetch that pops entries, decodes the access type and feeds the command queue
module robFetch import reqPkg::*; (
    input  logic       sclk,
    input  logic       sresetn,
    input  logic       robEmpty,
    output logic       robRd,
    input  robEntryT   robData,
    output logic       push,
    output queueEntryT pushEntry,
    input  logic       full
);

    typedef enum logic [1:0] {idle, pop, settle} fetchStateT;

    fetchStateT state;
    logic       validLos;

    always_ff @(posedge sclk or negedge sresetn) begin
        if (!sresetn) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (!robEmpty && !full)
                        state <= pop;
                end
                pop:     state <= settle;  // ROB flags lag the pop by two cycles
                default: state <= idle;
            endcase
        end
    end

    assign robRd    = (state == pop);
    assign validLos = (robData.los == LOS_WRITE) || (robData.los == LOS_READ);
    assign push     = robRd && validLos;  // Other codes are popped and dropped

    always_comb begin
        pushEntry.isWrite = (robData.los == LOS_WRITE);
        pushEntry.bank    = robData.bank;
        pushEntry.row     = robData.row;
        pushEntry.col     = robData.col;
    end

    // Queue room was checked in idle and only this block fills the queue
    assert property (@(posedge sclk) disable iff (!sresetn)
        robRd |-> !full);

endmodule

//--- src/sdramCmdGen.sv
`timescale 1ns/100ps
// SDRAM command generator top that links start-up, fetch, queue, refresh and pin logic
module sdramCmdGen import sdramPkg::*, reqPkg::*; (
    input  logic      sclk,
    input  logic      sresetn,
    input  logic      robEmpty,
    output logic      robRd,
    input  robEntryT  robData,
    output logic      qwdRd,
    output qwdAddrT   qwdAddr,
    input  wrDataT    qwdData,
    output sdramPinsT pins,
    output dataT      dq
);

    sdramCmdT   initCmd;
    logic       initDone;
    logic       push;
    queueEntryT pushEntry;
    logic       full;
    logic       empty;
    queueEntryT head;
    logic       pop;
    logic       refreshReq;
    logic       refreshAck;
    sdramCmdT   cmd;
    bankT       cmdBank;
    sdramAddrT  cmdAddr;

    initSequencer initSequencer_i (
        .sclk(sclk), .sresetn(sresetn), .initCmd(initCmd), .initDone(initDone)
    );

    robFetch robFetch_i (
        .sclk(sclk), .sresetn(sresetn), .robEmpty(robEmpty), .robRd(robRd),
        .robData(robData), .push(push), .pushEntry(pushEntry), .full(full)
    );

    cmdQueue #(.DEPTH(4)) cmdQueue_i (
        .sclk(sclk), .sresetn(sresetn), .push(push), .pushEntry(pushEntry),
        .pop(pop), .head(head), .empty(empty), .full(full)
    );

    refreshTimer refreshTimer_i (
        .sclk(sclk), .sresetn(sresetn), .refreshReq(refreshReq), .refreshAck(refreshAck)
    );

    bankSequencer bankSequencer_i (
        .sclk(sclk), .sresetn(sresetn), .initCmd(initCmd), .initDone(initDone),
        .empty(empty), .head(head), .pop(pop), .refreshReq(refreshReq),
        .refreshAck(refreshAck), .qwdRd(qwdRd), .qwdAddr(qwdAddr), .cmd(cmd),
        .cmdBank(cmdBank), .cmdAddr(cmdAddr)
    );

    pinEncoder pinEncoder_i (
        .sclk(sclk), .sresetn(sresetn), .cmd(cmd), .cmdBank(cmdBank),
        .cmdAddr(cmdAddr), .qwdData(qwdData), .pins(pins), .dq(dq)
    );

endmodule

//--- src/sdramPkg.sv
// SDRAM device package with timing, command set, mode word and pin bundle
package sdramPkg;

    // Timing in sclk cycles
    localparam int T_PR  = 3;     // Precharge
    localparam int T_WR  = 2;     // Write recovery
    localparam int T_RFC = 4686;  // 64 ms over 4096 rows at 300 MHz
    localparam int T_CBR = 9;     // Auto-refresh and precharge-all
    localparam int T_RCD = 3;     // Activate to column command
    localparam int T_CAS = 3;     // Read latency
    localparam int T_CP  = 6;     // Column access to precharge
    localparam int T_LD  = 5;     // Mode register load
    localparam int T_BL  = 8;     // Read burst

    typedef logic [1:0]  bankT;
    typedef logic [10:0] sdramAddrT;
    typedef logic [31:0] dataT;
    typedef logic [3:0]  maskT;
    typedef logic [4:0]  waitT;    // Longest wait is the read drain
    typedef logic [12:0] refCntT;  // Wide enough for T_RFC

    // CAS latency 3, sequential, burst field 0
    localparam sdramAddrT MODE_WORD = 11'h030;

    typedef enum logic [2:0] {
        cmdNop,
        cmdPreAll,
        cmdPreBank,
        cmdAct,
        cmdRead,
        cmdWrite,
        cmdRefresh,
        cmdLoadMode
    } sdramCmdT;

    typedef struct packed {
        logic      clkEn;
        logic      csn;
        logic      rasn;
        logic      casn;
        logic      wen;
        bankT      bank;
        sdramAddrT addr;
        maskT      dqm;
        logic      dqOe;
    } sdramPinsT;

    // Idle bus, also the value the pins hold in reset
    localparam sdramPinsT PINS_NOP = '{clkEn: 1'b1, csn: 1'b0, rasn: 1'b1, casn: 1'b1,
                                       wen: 1'b1, bank: '0, addr: '0, dqm: '0,
                                       dqOe: 1'b0};

endpackage

//--- tests/sdramCmdGenTb.sv
`timescale 1ns/100ps
// Testbench for the SDRAM command generator with ROB and write-data models and a pin monitor
module sdramCmdGenTb import sdramPkg::*, reqPkg::*; ();

    localparam int NUM_ROWS    = 16;
    localparam int PHASE1_ROWS = 8;                  // Preloaded before reset release
    localparam int PHASE2_AT   = T_RFC - 60;         // Second batch runs into the first refresh
    localparam int MAX_ACCESS  = T_RCD + T_CAS + T_BL + T_CP + T_PR + 4;
    localparam int TIMEOUT     = T_RFC * 2 + NUM_ROWS * 40;

    typedef struct packed {
        losT      los;
        bankT     bank;
        rowT      row;
        colT      col;
        sdramCmdT kind;  // Expected column command, cmdNop when dropped
    } stimRowT;

    localparam stimRowT STIM [NUM_ROWS] = '{
        '{2'b10, 2'd0, 11'h0a5, 8'h10, cmdRead},
        '{2'b01, 2'd1, 11'h1c3, 8'h24, cmdWrite},
        '{2'b00, 2'd2, 11'h055, 8'h08, cmdNop},
        '{2'b01, 2'd3, 11'h7ff, 8'hfc, cmdWrite},
        '{2'b10, 2'd2, 11'h300, 8'h00, cmdRead},
        '{2'b11, 2'd1, 11'h0ff, 8'h44, cmdNop},
        '{2'b01, 2'd0, 11'h001, 8'h84, cmdWrite},
        '{2'b10, 2'd3, 11'h4aa, 8'h7c, cmdRead},
        '{2'b01, 2'd2, 11'h2d2, 8'h38, cmdWrite},
        '{2'b10, 2'd1, 11'h123, 8'h9c, cmdRead},
        '{2'b01, 2'd0, 11'h666, 8'h60, cmdWrite},
        '{2'b00, 2'd3, 11'h010, 8'h14, cmdNop},
        '{2'b10, 2'd2, 11'h5a5, 8'he0, cmdRead},
        '{2'b01, 2'd3, 11'h3c3, 8'h2c, cmdWrite},
        '{2'b10, 2'd0, 11'h7e0, 8'hc8, cmdRead},
        '{2'b01, 2'd1, 11'h0f0, 8'h50, cmdWrite}
    };

    typedef struct {
        sdramCmdT  cmd;
        sdramPinsT pins;
        dataT      dq;
        int        cycle;
    } pinEventT;

    typedef struct {
        qwdAddrT addr;
        int      cycle;
    } qwdReadT;

    logic      sclk = 1'b0;
    logic      sresetn;
    logic      robEmpty;
    logic      robRd;
    robEntryT  robData;
    logic      qwdRd;
    qwdAddrT   qwdAddr;
    wrDataT    qwdData;
    sdramPinsT pins;
    dataT      dq;

    int        cycle = 0;      // Cycles since reset release
    int        errCount = 0;
    int        testCount = 0;
    int        okCount = 0;
    int        lastCycle;      // Last command that bounds the next ACT or refresh
    int        minNext;
    int        refreshCount = 0;

    robEntryT  robQ [$];
    logic      popSeen;
    wrDataT    mem [32];
    logic      rdPending;
    qwdAddrT   rdAddr;
    qwdReadT   qwdLog [$];
    pinEventT  evQ [$];

    always #10 sclk = ~sclk;

    sdramCmdGen sdramCmdGen_i (
        .sclk(sclk), .sresetn(sresetn), .robEmpty(robEmpty), .robRd(robRd),
        .robData(robData), .qwdRd(qwdRd), .qwdAddr(qwdAddr), .qwdData(qwdData),
        .pins(pins), .dq(dq)
    );

    // Pin truth table of the standard command set
    function automatic sdramCmdT decodePins(sdramPinsT p);
        if (p.csn)
            return cmdNop;
        case ({p.rasn, p.casn, p.wen})
            3'b011:  return cmdAct;
            3'b101:  return cmdRead;
            3'b100:  return cmdWrite;
            3'b010:  return cmdPreBank;  // Addr bit 10 widens it to all banks
            3'b001:  return cmdRefresh;
            3'b000:  return cmdLoadMode;
            default: return cmdNop;
        endcase
    endfunction

    function automatic sdramPinsT expectPins(sdramCmdT kind, bankT bank, sdramAddrT addr,
                                             maskT dqm);
        sdramPinsT p;
        p = PINS_NOP;
        case (kind)
            cmdAct:                {p.rasn, p.casn, p.wen} = 3'b011;
            cmdRead:               {p.rasn, p.casn, p.wen} = 3'b101;
            cmdWrite:              {p.rasn, p.casn, p.wen} = 3'b100;
            cmdPreAll, cmdPreBank: {p.rasn, p.casn, p.wen} = 3'b010;
            cmdRefresh:            {p.rasn, p.casn, p.wen} = 3'b001;
            cmdLoadMode:           {p.rasn, p.casn, p.wen} = 3'b000;
            default:               {p.rasn, p.casn, p.wen} = 3'b111;
        endcase
        p.bank = bank;
        p.addr = addr;
        p.dqm  = dqm;
        p.dqOe = (kind == cmdWrite);  // Bus driven on writes only
        return p;
    endfunction

    function automatic robEntryT makeEntry(int idx);
        robEntryT e;
        e.dAddr = 11'($urandom);  // Don't care fields
        e.size  = 2'($urandom);
        e.los   = STIM[idx].los;
        e.bank  = STIM[idx].bank;
        e.row   = STIM[idx].row;
        e.col   = STIM[idx].col;
        return e;
    endfunction

    task automatic checkCmd(string what, sdramCmdT got, sdramCmdT exp);
        if (got !== exp) begin
            errCount++;
            $display("CHECK FAILED %s cmd: got 0x%h (%s) expected 0x%h (%s)",
                     what, got, got.name(), exp, exp.name());
        end
    endtask

    task automatic checkPins(string what, sdramPinsT got, sdramPinsT exp);
        if (got !== exp) begin
            errCount++;
            $display("CHECK FAILED %s pins: got 0x%h expected 0x%h", what, got, exp);
        end
    endtask

    task automatic checkDq(string what, dataT got, dataT exp);
        if (got !== exp) begin
            errCount++;
            $display("CHECK FAILED %s dq: got 0x%h expected 0x%h", what, got, exp);
        end
    endtask

    task automatic checkQwdAddr(string what, qwdAddrT got, qwdAddrT exp);
        if (got !== exp) begin
            errCount++;
            $display("CHECK FAILED %s qwdAddr: got 0x%h expected 0x%h", what, got, exp);
        end
    endtask

    task automatic checkGap(string what, int gap, int minGap, int maxGap);
        if (gap < minGap || gap > maxGap) begin
            errCount++;
            $display("CHECK FAILED %s gap: got 0x%0h cycles expected 0x%0h to 0x%0h",
                     what, gap, minGap, maxGap);
        end
    endtask

    task automatic reportTest(string name, int errBefore);
        testCount++;
        if (errCount == errBefore) begin
            okCount++;
            $display("%-22s ok", name);
        end else begin
            $display("%-22s FAILED with %0d errors", name, errCount - errBefore);
        end
    endtask

    // ROB model, a pop seen mid-cycle takes effect after the next edge
    always @(negedge sclk) popSeen = robRd;

    always @(posedge sclk) begin
        #1;
        if (popSeen) begin
            if (robQ.size() == 0) begin
                errCount++;
                $display("ROB popped while it was empty at cycle %0d", cycle);
            end else begin
                void'(robQ.pop_front());
            end
        end
        if (cycle == PHASE2_AT) begin
            for (int i = PHASE1_ROWS; i < NUM_ROWS; i++)
                robQ.push_back(makeEntry(i));
        end
        robEmpty = (robQ.size() == 0);
        robData  = robEmpty ? '0 : robQ[0];
    end

    // Write-data store answers one cycle after the read strobe
    always @(negedge sclk) begin
        qwdReadT r;
        rdPending = qwdRd;
        rdAddr    = qwdAddr;
        if (qwdRd) begin
            r.addr  = qwdAddr;
            r.cycle = cycle;
            qwdLog.push_back(r);
        end
    end

    always @(posedge sclk) begin
        #1;
        if (rdPending)
            qwdData = mem[rdAddr];
    end

    // Pin monitor records every non-NOP command mid-cycle
    always @(negedge sclk) begin
        pinEventT ev;
        if (sresetn && decodePins(pins) != cmdNop) begin
            ev.cmd   = decodePins(pins);
            ev.pins  = pins;
            ev.dq    = dq;
            ev.cycle = cycle;
            evQ.push_back(ev);
        end else if (sresetn) begin
            // Quiet cycles keep the bus idle and undriven
            checkPins("NOP", pins, expectPins(cmdNop, '0, '0, '0));
            checkDq("NOP", dq, '0);
        end
    end

    always @(posedge sclk) begin
        if (sresetn)
            cycle++;
        if (cycle >= TIMEOUT) begin
            $display("Run stopped after %0d cycles without reaching the end of the tests", cycle);
            $display("test failed");
            $finish;
        end
    end

    task automatic nextEvent(output pinEventT ev);
        while (evQ.size() == 0)
            @(posedge sclk);
        ev = evQ.pop_front();
    endtask

    task automatic serveRefresh(input pinEventT ev);
        int errBefore;
        errBefore = errCount;
        checkPins("REF", ev.pins, expectPins(cmdRefresh, '0, '0, '0));
        checkGap("previous command to REF", ev.cycle - lastCycle, minNext, TIMEOUT);
        if (refreshCount == 0)
            checkGap("reset to first REF", ev.cycle, 1, T_RFC + MAX_ACCESS);
        refreshCount++;
        lastCycle = ev.cycle;
        minNext   = T_CBR;
        reportTest($sformatf("refresh %0d", refreshCount), errBefore);
    endtask

    // Refresh is only legal between a PRE and the next ACT
    task automatic nextAccessStart(output pinEventT ev);
        nextEvent(ev);
        while (ev.cmd == cmdRefresh) begin
            serveRefresh(ev);
            nextEvent(ev);
        end
    endtask

    task automatic checkAccess(int idx);
        stimRowT  s;
        pinEventT act;
        pinEventT col;
        pinEventT pre;
        qwdReadT  rd;
        wrDataT   word;
        int       preGap;
        int       errBefore;
        s    = STIM[idx];
        word = mem[s.col[6:2]];  // Store is addressed by column bits 6 to 2
        nextAccessStart(act);
        errBefore = errCount;
        checkCmd("ACT", act.cmd, cmdAct);
        checkPins("ACT", act.pins, expectPins(cmdAct, s.bank, s.row, '0));
        checkGap("previous command to ACT", act.cycle - lastCycle, minNext, TIMEOUT);
        nextEvent(col);
        checkCmd("column", col.cmd, s.kind);
        checkGap("ACT to column", col.cycle - act.cycle, T_RCD, T_RCD);
        if (s.kind == cmdWrite) begin
            checkPins("WR", col.pins, expectPins(cmdWrite, s.bank, sdramAddrT'(s.col), word.mask));
            checkDq("WR", col.dq, word.data);
            if (qwdLog.size() == 0) begin
                errCount++;
                $display("No write-data read was issued for table row %0d", idx);
            end else begin
                rd = qwdLog.pop_front();
                checkQwdAddr("WR", rd.addr, s.col[6:2]);
                checkGap("qwdRd to WR", col.cycle - rd.cycle, 1, 1);
            end
            preGap = T_WR + T_CP;
        end else begin
            checkPins("RD", col.pins, expectPins(cmdRead, s.bank, sdramAddrT'(s.col), '0));
            preGap = T_CAS + T_BL + T_CP;
        end
        nextEvent(pre);
        checkCmd("PRE", pre.cmd, cmdPreBank);
        checkPins("PRE", pre.pins, expectPins(cmdPreBank, s.bank, 11'h400, '0));
        checkGap("column to PRE", pre.cycle - col.cycle, preGap, preGap);
        lastCycle = pre.cycle;
        minNext   = T_PR;
        reportTest($sformatf("row %0d %s", idx, s.kind.name()), errBefore);
    endtask

    // Dropped rows are confirmed once the next valid row matches
    task automatic runRows(int from, int to, string label);
        int errBefore;
        int rowErr;
        int dropped [$];
        errBefore = errCount;
        for (int i = from; i < to; i++) begin
            if (STIM[i].kind == cmdNop) begin
                dropped.push_back(i);
            end else begin
                rowErr = errCount;
                checkAccess(i);
                while (dropped.size() > 0)
                    reportTest($sformatf("row %0d dropped", dropped.pop_front()), rowErr);
            end
        end
        reportTest(label, errBefore);
    endtask

    initial begin
        pinEventT ev;
        pinEventT preAll;
        int       errBefore;
        sresetn   = 1'b0;
        robEmpty  = 1'b1;
        robData   = '0;
        qwdData   = '0;
        popSeen   = 1'b0;
        rdPending = 1'b0;
        rdAddr    = '0;
        void'($urandom(69958));
        for (int a = 0; a < 32; a++) begin
            mem[a].data = $urandom;
            mem[a].mask = maskT'($urandom);
        end
        for (int i = 0; i < PHASE1_ROWS; i++)
            robQ.push_back(makeEntry(i));
        repeat (10) @(posedge sclk);
        #1;
        sresetn = 1'b1;

        errBefore = errCount;
        nextEvent(preAll);
        checkPins("PRE all", preAll.pins, expectPins(cmdPreAll, '0, 11'h400, '0));
        checkGap("reset to PRE all", preAll.cycle, 1, 1);
        nextEvent(ev);
        checkCmd("LOAD", ev.cmd, cmdLoadMode);
        checkPins("LOAD", ev.pins, expectPins(cmdLoadMode, '0, MODE_WORD, '0));
        checkGap("PRE all to LOAD", ev.cycle - preAll.cycle, T_CBR, T_CBR);
        lastCycle = ev.cycle;
        minNext   = T_LD + 1;  // Mode load must settle before any ACT
        reportTest("startup", errBefore);

        runRows(0, PHASE1_ROWS, "preloaded order");
        runRows(PHASE1_ROWS, NUM_ROWS, "second batch order");
        while (refreshCount == 0) begin
            nextEvent(ev);
            checkCmd("REF", ev.cmd, cmdRefresh);
            serveRefresh(ev);
        end

        $display("tests %0d, ok %0d, errors %0d", testCount, okCount, errCount);
        if (errCount == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule
